// ==== src/fp_pkg.sv ====
// single-precision format types, class and rounding enums, constants shared by the adder
`default_nettype none

package fp_pkg;

  // packed IEEE-754 single word
  typedef logic [31:0] float_t;

  // unbiased exponent, signed, with headroom both ways
  typedef logic signed [9:0] exp_t;

  // significand including the hidden one
  typedef logic [23:0] sig_t;

  // carry, 24 significand bits, guard, round, sticky
  typedef logic [27:0] wide_sig_t;

  typedef enum logic [1:0] {
    class_zero,
    class_normal,
    class_inf,
    class_nan
  } fp_class_t;

  // round to nearest even or toward zero
  typedef enum logic {
    rne,
    rtz
  } rounding_mode_t;

  localparam exp_t exp_bias = 10'sd127;
  localparam exp_t exp_max = 10'sd127;
  localparam exp_t exp_min = -10'sd126;

  // beyond this difference the smaller operand is only sticky
  localparam exp_t align_limit = 10'sd26;

  // the one NaN the adder ever returns
  localparam float_t qnan_value = 32'h7fc0_0000;

endpackage

`default_nettype wire

// ==== src/fp_unpack.sv ====
// splits one packed operand into class, sign, unbiased exponent and significand
`timescale 1ns/1ps
`default_nettype none

module fp_unpack (
  input  fp_pkg::float_t    f,
  output fp_pkg::fp_class_t cls,
  output logic              sign,
  output fp_pkg::exp_t      exponent,
  output fp_pkg::sig_t      significand
);

  logic [7:0]  exp_field;
  logic [22:0] frac_field;

  assign sign       = f[31];
  assign exp_field  = f[30:23];
  assign frac_field = f[22:0];

  always_comb begin
    cls         = fp_pkg::class_normal;
    exponent    = '0;
    significand = '0;
    if (exp_field == 8'h00) begin
      // subnormals are flushed, the sign survives
      cls = fp_pkg::class_zero;
    end else if (exp_field == 8'hff) begin
      cls = (frac_field == '0) ? fp_pkg::class_inf : fp_pkg::class_nan;
    end else begin
      exponent    = fp_pkg::exp_t'({2'b00, exp_field}) - fp_pkg::exp_bias;
      significand = {1'b1, frac_field};
    end
  end

endmodule

`default_nettype wire

// ==== src/fp_align.sv ====
// orders two unpacked operands by magnitude and aligns the smaller significand
`timescale 1ns/1ps
`default_nettype none

module fp_align (
  input  logic                is_sub,
  input  logic                a_sign,
  input  logic                b_sign,
  input  fp_pkg::exp_t        a_exp,
  input  fp_pkg::exp_t        b_exp,
  input  fp_pkg::sig_t        a_sig,
  input  fp_pkg::sig_t        b_sig,
  output logic                result_sign,
  output fp_pkg::exp_t        large_exp,
  output fp_pkg::wide_sig_t   large_sig,
  output fp_pkg::wide_sig_t   small_sig,
  output logic                eff_sub
);

  logic              a_larger;
  fp_pkg::exp_t      shift_amt;
  fp_pkg::sig_t      small_base;
  fp_pkg::wide_sig_t small_wide;
  fp_pkg::wide_sig_t shifted;
  fp_pkg::wide_sig_t lost_mask;
  logic              lost;

  // exponent first, significand breaks the tie
  assign a_larger = (a_exp > b_exp) || ((a_exp == b_exp) && (a_sig > b_sig));

  // b enters negated for a subtract
  assign eff_sub     = a_sign ^ b_sign ^ is_sub;
  assign result_sign = a_larger ? a_sign : (b_sign ^ is_sub);

  assign large_exp  = a_larger ? a_exp : b_exp;
  assign shift_amt  = a_larger ? (a_exp - b_exp) : (b_exp - a_exp);
  assign small_base = a_larger ? b_sig : a_sig;

  assign large_sig  = {1'b0, (a_larger ? a_sig : b_sig), 3'b000};
  assign small_wide = {1'b0, small_base, 3'b000};

  always_comb begin
    lost_mask = '1;
    lost_mask = ~(lost_mask << shift_amt[4:0]);
    shifted   = small_wide >> shift_amt[4:0];
    lost      = |(small_wide & lost_mask);
    if (shift_amt > fp_pkg::align_limit) begin
      // too far out to touch anything but sticky
      small_sig = {27'd0, |small_base};
    end else begin
      small_sig = {shifted[27:1], shifted[0] | lost};
    end
  end

endmodule

`default_nettype wire

// ==== src/fp_add_normalise.sv ====
// adds or subtracts aligned significands and renormalises so the hidden bit is set
`timescale 1ns/1ps
`default_nettype none

module fp_add_normalise (
  input  logic              eff_sub,
  input  fp_pkg::exp_t      large_exp,
  input  fp_pkg::wide_sig_t large_sig,
  input  fp_pkg::wide_sig_t small_sig,
  output fp_pkg::exp_t      norm_exp,
  output fp_pkg::wide_sig_t norm_sig,
  output logic              exact_zero
);

  fp_pkg::wide_sig_t sum;
  logic [4:0]        lead_zeros;
  logic              found;

  // large is never below small, so no borrow out
  assign sum        = eff_sub ? (large_sig - small_sig) : (large_sig + small_sig);
  assign exact_zero = (sum == '0);

  // count zeros above the first set bit, carry excluded
  always_comb begin
    lead_zeros = '0;
    found      = 1'b0;
    for (int i = 26; i >= 0; i--) begin
      if (!found) begin
        if (sum[i]) begin
          found = 1'b1;
        end else begin
          lead_zeros = lead_zeros + 5'd1;
        end
      end
    end
  end

  always_comb begin
    if (sum[27]) begin
      // carry out, shift right and fold the lost bit into sticky
      norm_sig = {1'b0, sum[27:2], sum[1] | sum[0]};
      norm_exp = large_exp + 10'sd1;
    end else begin
      // covers single-bit far-path cancellation and deep near-path cancellation
      norm_sig = sum << lead_zeros;
      norm_exp = large_exp - fp_pkg::exp_t'({5'd0, lead_zeros});
    end
  end

endmodule

`default_nettype wire

// ==== src/fp_round_pack.sv ====
// rounds the normalised sum, resolves special operands and packs the final word
`timescale 1ns/1ps
`default_nettype none

module fp_round_pack (
  input  fp_pkg::rounding_mode_t rounding_mode,
  input  logic                   is_sub,
  input  fp_pkg::fp_class_t      a_cls,
  input  fp_pkg::fp_class_t      b_cls,
  input  logic                   a_sign,
  input  logic                   b_sign,
  input  fp_pkg::float_t         a_in,
  input  fp_pkg::float_t         b_in,
  input  logic                   result_sign,
  input  fp_pkg::exp_t           norm_exp,
  input  fp_pkg::wide_sig_t      norm_sig,
  input  logic                   exact_zero,
  output fp_pkg::float_t         result
);

  logic           guard_bit;
  logic           round_bit;
  logic           sticky_bit;
  logic           round_up;
  logic [24:0]    rounded;
  fp_pkg::sig_t   rnd_sig;
  fp_pkg::exp_t   rnd_exp;
  fp_pkg::exp_t   biased;
  logic           b_eff_sign;
  fp_pkg::float_t finite_result;

  assign guard_bit  = norm_sig[2];
  assign round_bit  = norm_sig[1];
  assign sticky_bit = norm_sig[0];

  // ties go to an even lsb
  assign round_up = (rounding_mode == fp_pkg::rne) && guard_bit &&
                    (round_bit || sticky_bit || norm_sig[3]);
  assign rounded  = {1'b0, norm_sig[26:3]} + {24'd0, round_up};

  // all ones plus one wraps to 1.0 of the next binade
  assign rnd_sig = rounded[24] ? rounded[24:1] : rounded[23:0];
  assign rnd_exp = rounded[24] ? (norm_exp + 10'sd1) : norm_exp;
  assign biased  = rnd_exp + fp_pkg::exp_bias;

  assign b_eff_sign = b_sign ^ is_sub;

  always_comb begin
    if (rnd_exp > fp_pkg::exp_max) begin
      if (rounding_mode == fp_pkg::rne) begin
        finite_result = {result_sign, 8'hff, 23'd0};
      end else begin
        // largest finite magnitude
        finite_result = {result_sign, 8'hfe, 23'h7fffff};
      end
    end else if (rnd_exp < fp_pkg::exp_min) begin
      finite_result = {result_sign, 31'd0};
    end else begin
      finite_result = {result_sign, biased[7:0], rnd_sig[22:0]};
    end
  end

  // special operands take priority over the datapath
  always_comb begin
    if ((a_cls == fp_pkg::class_nan) || (b_cls == fp_pkg::class_nan)) begin
      result = fp_pkg::qnan_value;
    end else if ((a_cls == fp_pkg::class_inf) && (b_cls == fp_pkg::class_inf) &&
                 (a_sign != b_eff_sign)) begin
      result = fp_pkg::qnan_value;
    end else if (a_cls == fp_pkg::class_inf) begin
      result = {a_sign, 8'hff, 23'd0};
    end else if (b_cls == fp_pkg::class_inf) begin
      result = {b_eff_sign, 8'hff, 23'd0};
    end else if ((a_cls == fp_pkg::class_zero) && (b_cls == fp_pkg::class_zero)) begin
      result = {a_sign & b_eff_sign, 31'd0};
    end else if (a_cls == fp_pkg::class_zero) begin
      result = {b_eff_sign, b_in[30:0]};
    end else if (b_cls == fp_pkg::class_zero) begin
      result = a_in;
    end else if (exact_zero) begin
      result = '0;
    end else begin
      result = finite_result;
    end
  end

endmodule

`default_nettype wire

// ==== src/fp_add_sub.sv ====
// single-precision add/subtract unit, operands taken and result returned over req/ack
`timescale 1ns/1ps
`default_nettype none

module fp_add_sub (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  output logic                   ack,
  input  logic                   is_sub,
  input  fp_pkg::rounding_mode_t rounding_mode,
  input  fp_pkg::float_t         a,
  input  fp_pkg::float_t         b,
  output fp_pkg::float_t         result
);

  typedef enum logic [1:0] {
    idle,
    busy,
    done
  } state_t;

  state_t state;

  logic                   is_sub_q;
  fp_pkg::rounding_mode_t mode_q;
  fp_pkg::float_t         a_q;
  fp_pkg::float_t         b_q;
  fp_pkg::float_t         result_q;

  fp_pkg::fp_class_t a_cls, b_cls;
  logic              a_sign, b_sign;
  fp_pkg::exp_t      a_exp, b_exp;
  fp_pkg::sig_t      a_sig, b_sig;

  logic              result_sign;
  logic              eff_sub;
  fp_pkg::exp_t      large_exp;
  fp_pkg::wide_sig_t large_sig;
  fp_pkg::wide_sig_t small_sig;

  fp_pkg::exp_t      norm_exp;
  fp_pkg::wide_sig_t norm_sig;
  logic              exact_zero;
  fp_pkg::float_t    dp_result;

  // four-phase control, one cycle from capture to ack
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      case (state)
        idle:    if (req) state <= busy;
        busy:    state <= done;
        done:    if (!req) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == idle) && req) begin
      is_sub_q <= is_sub;
      mode_q   <= rounding_mode;
      a_q      <= a;
      b_q      <= b;
    end
    if (state == busy) begin
      result_q <= dp_result;
    end
  end

  assign ack    = (state == done);
  assign result = result_q;

  fp_unpack u_unpack_a (
    .f           (a_q),
    .cls         (a_cls),
    .sign        (a_sign),
    .exponent    (a_exp),
    .significand (a_sig)
  );

  fp_unpack u_unpack_b (
    .f           (b_q),
    .cls         (b_cls),
    .sign        (b_sign),
    .exponent    (b_exp),
    .significand (b_sig)
  );

  fp_align u_align (
    .is_sub      (is_sub_q),
    .a_sign      (a_sign),
    .b_sign      (b_sign),
    .a_exp       (a_exp),
    .b_exp       (b_exp),
    .a_sig       (a_sig),
    .b_sig       (b_sig),
    .result_sign (result_sign),
    .large_exp   (large_exp),
    .large_sig   (large_sig),
    .small_sig   (small_sig),
    .eff_sub     (eff_sub)
  );

  fp_add_normalise u_add_normalise (
    .eff_sub    (eff_sub),
    .large_exp  (large_exp),
    .large_sig  (large_sig),
    .small_sig  (small_sig),
    .norm_exp   (norm_exp),
    .norm_sig   (norm_sig),
    .exact_zero (exact_zero)
  );

  fp_round_pack u_round_pack (
    .rounding_mode (mode_q),
    .is_sub        (is_sub_q),
    .a_cls         (a_cls),
    .b_cls         (b_cls),
    .a_sign        (a_sign),
    .b_sign        (b_sign),
    .a_in          (a_q),
    .b_in          (b_q),
    .result_sign   (result_sign),
    .norm_exp      (norm_exp),
    .norm_sig      (norm_sig),
    .exact_zero    (exact_zero),
    .result        (dp_result)
  );

endmodule

`default_nettype wire

// ==== verification/fp_add_sub_properties.sv ====
// handshake assertions for the add/subtract unit, bound into fp_add_sub
`timescale 1ns/1ps
`default_nettype none

module fp_add_sub_properties (
  input logic           clk,
  input logic           rst_n,
  input logic           req,
  input logic           ack,
  input fp_pkg::float_t result
);

  // ack is registered, so it is low from the edge after reset is seen
  ack_low_in_reset: assert property (@(posedge clk) !rst_n |=> !ack)
    else $error("ack high after a reset cycle");

  ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req))
    else $error("ack rose while req was low");

  ack_fall_needs_release: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(ack) |-> $past(!req))
    else $error("ack fell while req was still high");

  result_held_with_ack: assert property (@(posedge clk) disable iff (!rst_n)
    ack |=> (!ack || $stable(result)))
    else $error("result changed while ack was high");

endmodule

bind fp_add_sub fp_add_sub_properties u_properties (
  .clk    (clk),
  .rst_n  (rst_n),
  .req    (req),
  .ack    (ack),
  .result (result)
);

`default_nettype wire

// ==== verification/fp_add_sub_tb.sv ====
// testbench for the add/subtract unit that runs every vector of the testdata file over req/ack
`timescale 1ns/1ps
`default_nettype none

module fp_add_sub_tb;

  logic                   clk;
  logic                   rst_n;
  logic                   req;
  logic                   ack;
  logic                   is_sub;
  fp_pkg::rounding_mode_t rounding_mode;
  fp_pkg::float_t         a;
  fp_pkg::float_t         b;
  fp_pkg::float_t         result;

  // one entry per vector line
  logic [191:0]           name_q[$];
  logic                   is_sub_q[$];
  fp_pkg::rounding_mode_t mode_q[$];
  fp_pkg::float_t         a_q[$];
  fp_pkg::float_t         b_q[$];
  fp_pkg::float_t         expected_q[$];

  int   vector_count;
  logic vectors_loaded;

  fp_add_sub u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .req           (req),
    .ack           (ack),
    .is_sub        (is_sub),
    .rounding_mode (rounding_mode),
    .a             (a),
    .b             (b),
    .result        (result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_float(input logic [191:0] name, input fp_pkg::float_t expected,
                             input fp_pkg::float_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %0s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_ack(input logic [191:0] name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] %0s ack: expected %b, actual %b", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic load_vectors();
    int             fd;
    int             code;
    string          line;
    logic [191:0]   name;
    logic [3:0]     sub_val;
    logic [3:0]     mode_val;
    fp_pkg::float_t a_val;
    fp_pkg::float_t b_val;
    fp_pkg::float_t exp_val;
    fd = $fopen("verification/fp_add_sub_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
      abort_run();
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      // blank lines and comment lines carry no vector
      if ((code > 1) && (line.getc(0) != "#")) begin
        code = $sscanf(line, "%s %h %h %h %h %h", name, sub_val, mode_val,
                       a_val, b_val, exp_val);
        if (code != 6) begin
          $display("malformed vector line: %0s", line);
          abort_run();
        end
        name_q.push_back(name);
        is_sub_q.push_back(sub_val[0]);
        mode_q.push_back(fp_pkg::rounding_mode_t'(mode_val[0]));
        a_q.push_back(a_val);
        b_q.push_back(b_val);
        expected_q.push_back(exp_val);
      end
    end
    $fclose(fd);
    vector_count = name_q.size();
    if (vector_count == 0) begin
      $display("the vector file holds no vectors");
      abort_run();
    end
  endtask

  // waits on falling edges for ack to reach a level
  task automatic wait_for_ack(input logic level, input logic [191:0] name);
    int cycles;
    cycles = 0;
    while (ack !== level) begin
      @(negedge clk);
      cycles++;
      if (cycles > 8) begin
        $display("timeout: ack never went to %0b during %0s", level, name);
        abort_run();
      end
    end
  endtask

  task automatic run_vector(input int idx);
    @(negedge clk);
    is_sub        = is_sub_q[idx];
    rounding_mode = mode_q[idx];
    a             = a_q[idx];
    b             = b_q[idx];
    req           = 1'b1;
    // only the capture edge has passed so ack is still low
    @(negedge clk);
    check_ack(name_q[idx], 1'b0, ack);
    wait_for_ack(1'b1, name_q[idx]);
    check_float(name_q[idx], expected_q[idx], result);
    req = 1'b0;
    wait_for_ack(1'b0, name_q[idx]);
  endtask

  initial begin
    rst_n          = 1'b0;
    req            = 1'b0;
    is_sub         = 1'b0;
    rounding_mode  = fp_pkg::rne;
    a              = '0;
    b              = '0;
    vector_count   = 0;
    vectors_loaded = 1'b0;
    load_vectors();
    vectors_loaded = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_ack("reset", 1'b0, ack);
    rst_n = 1'b1;
    for (int i = 0; i < vector_count; i++) begin
      run_vector(i);
    end
    $display("All checks passed");
    $finish;
  end

  // budget of 20 cycles per vector on top of reset
  initial begin
    wait (vectors_loaded);
    repeat (vector_count * 20 + 4) @(posedge clk);
    $display("timeout: the vectors did not finish in %0d cycles", vector_count * 20 + 4);
    abort_run();
  end

endmodule

`default_nettype wire

// ==== all.f ====
src/fp_pkg.sv
src/fp_unpack.sv
src/fp_align.sv
src/fp_add_normalise.sv
src/fp_round_pack.sv
src/fp_add_sub.sv
verification/fp_add_sub_properties.sv
verification/fp_add_sub_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the add/subtract testbench, pass only if the log holds the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module fp_add_sub_tb \
  -o fp_add_sub_sim > build.log 2>&1 &&
./obj_dir/fp_add_sub_sim > sim.log 2>&1 || { echo "build or simulation error"; exit 1; }
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verification/fp_add_sub_testdata.txt ====
# columns: test name, is_sub, mode (0 rne, 1 rtz), a, b, expected result
# all columns after the name are hex
add_basic 0 0 3f800000 40000000 40400000
sub_neg_result 1 0 3f800000 40400000 c0000000
add_carry 0 0 3fc00000 3fc00000 40400000
add_far 0 0 3f800000 30800000 3f800000
tie_even_down 0 0 3f800000 33800000 3f800000
tie_even_up 0 0 3f800001 33800000 3f800002
inexact_rne 0 0 3f800000 33c00000 3f800001
inexact_rtz 0 1 3f800000 33c00000 3f800000
far_sub_rtz 1 1 3f800000 30800000 3f7fffff
near_cancel 1 0 3f800001 3f800000 34000000
exact_cancel 1 0 40400000 40400000 00000000
overflow_rne 0 0 7f7fffff 7f7fffff 7f800000
overflow_rtz 0 1 7f7fffff 7f7fffff 7f7fffff
nan_a 0 0 7fc00000 3f800000 7fc00000
nan_b_signalling 1 0 3f800000 ff800001 7fc00000
inf_minus_inf 1 0 7f800000 7f800000 7fc00000
finite_minus_inf 1 0 3f800000 7f800000 ff800000
zero_plus_neg_zero 0 0 00000000 80000000 00000000
neg_zero_minus_zero 1 0 80000000 00000000 80000000
zero_minus_x 1 0 00000000 3f800000 bf800000
subnormal_a 0 0 00000001 3f800000 3f800000
flush_neg 1 0 00800000 00800001 80000000
